// File: Bender.yml
package:
  name: cpuLocalBus

sources:
  - hdl/localBusPkg.sv
  - hdl/busIfs.sv
  - hdl/addressDecode.sv
  - hdl/cycleControl.sv
  - hdl/registerFile.sv
  - hdl/ramController.sv
  - hdl/transferAck.sv
  - hdl/cpuLocalBus.sv
  - target: test
    files:
      - testbench/cpuLocalBusTb.sv

// File: cpuLocalBus.f
hdl/localBusPkg.sv
hdl/busIfs.sv
hdl/addressDecode.sv
hdl/cycleControl.sv
hdl/registerFile.sv
hdl/ramController.sv
hdl/transferAck.sv
hdl/cpuLocalBus.sv
testbench/cpuLocalBusTb.sv

// File: hdl/addressDecode.sv
// Captures the bus address at transfer start and holds the addressed space until the cycle ends.
`timescale 1ns/10ps
`default_nettype none

module addressDecode (
    input logic CLK40,
    input logic nRESET,
    input logic nTs,
    input logic [31:0] addr,
    input logic cycleDone,
    output localBusPkg::busSpace_e space,
    output logic [31:0] lineAddr
);

    localBusPkg::busSpace_e nextSpace;
    logic regHit;
    logic ramHit;

    // Compare only the bits above each space's span.
    assign regHit = addr[31:localBusPkg::REG_SPAN_W] ==
                    localBusPkg::REG_BASE[31:localBusPkg::REG_SPAN_W];
    assign ramHit = addr[31:localBusPkg::RAM_SPAN_W] ==
                    localBusPkg::RAM_BASE[31:localBusPkg::RAM_SPAN_W];

    always_comb begin
        if (regHit) begin
            nextSpace = localBusPkg::SPACE_REG;
        end else if (ramHit) begin
            nextSpace = localBusPkg::SPACE_RAM;
        end else begin
            nextSpace = localBusPkg::SPACE_NONE;        // Not ours, stay off the bus.
        end
    end

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            space <= localBusPkg::SPACE_NONE;
        end else if (!nTs) begin
            space <= nextSpace;                         // Edge 0 of the cycle.
        end else if (cycleDone) begin
            space <= localBusPkg::SPACE_NONE;           // End of the recovery cycle.
        end
    end

    // Address for the datapaths, kept while the CPU moves on.
    always_ff @(posedge CLK40) begin
        if (!nTs) begin
            lineAddr <= addr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/busIfs.sv
// Request and acknowledge interfaces between the cycle controller and the register and RAM datapaths.
`timescale 1ns/10ps
`default_nettype none

interface regBusIf;
    logic request;                                      // One-cycle pulse at cycle start.
    logic [localBusPkg::REG_IDX_W-1:0] index;           // Held for the whole cycle.
    logic rnw;
    logic [31:0] wdata;                                 // CPU write data, straight through.
    logic [31:0] rdata;                                 // Valid only with ta.
    logic ta;                                           // Single acknowledge pulse.

    modport master (output request, index, rnw, wdata, input rdata, ta);
    modport slave (input request, index, rnw, wdata, output rdata, ta);
endinterface

interface ramBusIf;
    logic request;                                      // One-cycle pulse at cycle start.
    logic [localBusPkg::RAM_ADDR_W-1:0] wordAddr;       // Start word of the cycle.
    logic rnw;
    logic burst;                                        // CPU asked for a line burst.
    logic [31:0] wdata;
    logic [31:0] rdata;                                 // Valid only with ta.
    logic ta;                                           // One pulse per beat.
    logic burstCycle;                                   // Low on a refused burst.

    modport master (
        output request, wordAddr, rnw, burst, wdata,
        input rdata, ta, burstCycle
    );
    modport slave (
        input request, wordAddr, rnw, burst, wdata,
        output rdata, ta, burstCycle
    );
endinterface

`default_nettype wire

// File: hdl/cpuLocalBus.sv
// Top level of the MC68040-style local-bus slave, joining decoder, controller, datapaths and strobe drivers.
`timescale 1ns/10ps
`default_nettype none

module cpuLocalBus (
    input logic CLK40,
    input logic nRESET,
    input logic nTs,
    input logic [31:0] addr,
    input logic rnw,
    input logic lineBurst,
    input logic [31:0] writeData,
    input logic dmaReq,
    output logic [31:0] readData,
    output tri nTa,
    output tri nTbi
);

    localBusPkg::busSpace_e space;
    logic [31:0] lineAddr;
    logic cycleDone;

    regBusIf regBus ();
    ramBusIf ramBus ();

    addressDecode addressDecode_i (
        .CLK40(CLK40),
        .nRESET(nRESET),
        .nTs(nTs),
        .addr(addr),
        .cycleDone(cycleDone),
        .space(space),
        .lineAddr(lineAddr)
    );

    cycleControl cycleControl_i (
        .CLK40(CLK40),
        .nRESET(nRESET),
        .nTs(nTs),
        .rnw(rnw),
        .lineBurst(lineBurst),
        .writeData(writeData),
        .space(space),
        .lineAddr(lineAddr),
        .cycleDone(cycleDone),
        .regBus(regBus.master),
        .ramBus(ramBus.master)
    );

    registerFile registerFile_i (
        .CLK40(CLK40),
        .nRESET(nRESET),
        .regBus(regBus.slave)
    );

    ramController ramController_i (
        .CLK40(CLK40),
        .nRESET(nRESET),
        .dmaReq(dmaReq),
        .ramBus(ramBus.slave)
    );

    transferAck transferAck_i (
        .CLK40(CLK40),
        .nRESET(nRESET),
        .regTa(regBus.ta),
        .ramTa(ramBus.ta),
        .burstCycle(ramBus.burstCycle),
        .space(space),
        .nTa(nTa),
        .nTbi(nTbi)
    );

    // Read data from the active space, zero otherwise.
    always_comb begin
        case (space)
            localBusPkg::SPACE_REG: readData = regBus.rdata;
            localBusPkg::SPACE_RAM: readData = ramBus.rdata;
            default: readData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/cycleControl.sv
// Bus cycle sequencer: starts the addressed datapath, follows its acknowledges and counts burst beats.
`timescale 1ns/10ps
`default_nettype none

module cycleControl (
    input logic CLK40,
    input logic nRESET,
    input logic nTs,
    input logic rnw,
    input logic lineBurst,
    input logic [31:0] writeData,
    input localBusPkg::busSpace_e space,
    input logic [31:0] lineAddr,
    output logic cycleDone,
    regBusIf.master regBus,
    ramBusIf.master ramBus
);

    localBusPkg::cycleState_e state;
    logic launch;                                       // First cycle after nTs.
    logic rnwQ;
    logic burstQ;
    logic [localBusPkg::BEAT_W-1:0] beatCnt;
    logic ta;
    logic lastBeat;

    assign ta = regBus.ta || ramBus.ta;

    // One beat unless a granted RAM burst still has beats to go.
    assign lastBeat = (space != localBusPkg::SPACE_RAM) || !burstQ || !ramBus.burstCycle ||
                      (beatCnt == localBusPkg::LAST_BEAT);

    // Request goes only to the space the decoder picked.
    assign regBus.request = launch && (space == localBusPkg::SPACE_REG);
    assign regBus.index = lineAddr[2 +: localBusPkg::REG_IDX_W];
    assign regBus.rnw = rnwQ;
    assign regBus.wdata = writeData;                    // CPU holds data until nTa.

    assign ramBus.request = launch && (space == localBusPkg::SPACE_RAM);
    assign ramBus.wordAddr = lineAddr[2 +: localBusPkg::RAM_ADDR_W];
    assign ramBus.rnw = rnwQ;
    assign ramBus.burst = burstQ;
    assign ramBus.wdata = writeData;

    // Decoder releases the space at the end of recovery.
    assign cycleDone = (state == localBusPkg::ST_RECOVER);

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            state <= localBusPkg::ST_IDLE;
            launch <= 1'b0;
            rnwQ <= 1'b0;
            burstQ <= 1'b0;
            beatCnt <= '0;
        end else begin
            launch <= 1'b0;
            case (state)
                localBusPkg::ST_IDLE: begin
                    if (!nTs) begin
                        state <= localBusPkg::ST_WAIT;
                        launch <= 1'b1;
                        rnwQ <= rnw;                    // Cycle attributes sampled with nTs.
                        burstQ <= lineBurst;
                        beatCnt <= '0;
                    end
                end
                localBusPkg::ST_WAIT: begin
                    if (space == localBusPkg::SPACE_NONE) begin
                        state <= localBusPkg::ST_IDLE;  // Unclaimed, back at edge 1.
                    end else if (ta) begin
                        beatCnt <= beatCnt + 1'b1;
                        state <= lastBeat ? localBusPkg::ST_RECOVER : localBusPkg::ST_BEAT;
                    end
                end
                localBusPkg::ST_BEAT: begin
                    if (ta) begin
                        beatCnt <= beatCnt + 1'b1;
                        if (lastBeat) begin
                            state <= localBusPkg::ST_RECOVER;
                        end
                    end
                end
                localBusPkg::ST_RECOVER: begin
                    state <= localBusPkg::ST_IDLE;      // nTa driven high this cycle.
                end
                default: begin
                    state <= localBusPkg::ST_IDLE;
                end
            endcase
        end
    end

    // CPU starts nothing until recovery is over.
    tsOnlyInIdle: assert property (
        @(posedge CLK40) disable iff (!nRESET)
        !nTs |-> state == localBusPkg::ST_IDLE
    );

    // Datapath acknowledges stay inside the cycle window.
    taOnlyInCycle: assert property (
        @(posedge CLK40) disable iff (!nRESET)
        ta |-> state inside {localBusPkg::ST_WAIT, localBusPkg::ST_BEAT}
    );

endmodule

`default_nettype wire

// File: hdl/localBusPkg.sv
// Address map, RAM geometry, cycle timing and state encodings shared by the local-bus slave RTL.
`default_nettype none

package localBusPkg;

    // Register space.
    localparam logic [31:0] REG_BASE = 32'h00F0_0000;   // Four longwords at the base.
    localparam int REG_COUNT = 4;                       // Control registers.
    localparam int REG_IDX_W = $clog2(REG_COUNT);       // Index from address bits 3..2.
    localparam int REG_SPAN_W = REG_IDX_W + 2;          // Byte offset bits in the space.

    // RAM space held in block memory.
    localparam logic [31:0] RAM_BASE = 32'h0800_0000;   // 4 KB window.
    localparam int RAM_WORDS = 1024;                    // Depth in longwords.
    localparam int RAM_ADDR_W = 10;                     // Longword address width.
    localparam int RAM_SPAN_W = RAM_ADDR_W + 2;         // Byte offset bits in the space.

    // Line bursts.
    localparam int BEATS_PER_LINE = 4;                  // Longwords per 16-byte line.
    localparam int BEAT_W = $clog2(BEATS_PER_LINE);     // Wrapping part of the word address.
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BEATS_PER_LINE - 1);

    // Wait states, counted from the edge that samples nTs low.
    localparam int REG_WAIT = 2;                        // Edge of the register acknowledge.
    localparam int RAM_WAIT = 3;                        // Edge of the first RAM beat.
    localparam int WAIT_W = $clog2(RAM_WAIT);           // RAM wait counter width.
    // Request is seen one edge late and the fetch edge counts as the last one.
    localparam logic [WAIT_W-1:0] WAIT_LOAD = WAIT_W'(RAM_WAIT - 2);

    // Which slave space a cycle addresses.
    typedef enum logic [1:0] {
        SPACE_NONE,                                     // Unclaimed, left to another slave.
        SPACE_REG,
        SPACE_RAM
    } busSpace_e;

    // Cycle controller states.
    typedef enum logic [1:0] {
        ST_IDLE,                                        // Waiting for nTs.
        ST_WAIT,                                        // Request out, first ta pending.
        ST_BEAT,                                        // Later burst beats.
        ST_RECOVER                                      // nTa driven high for one cycle.
    } cycleState_e;

endpackage

`default_nettype wire

// File: hdl/ramController.sv
// On-chip RAM slave with wait states, wrapping line bursts and burst refusal while DMA is pending.
`timescale 1ns/10ps
`default_nettype none

module ramController (
    input logic CLK40,
    input logic nRESET,
    input logic dmaReq,
    ramBusIf.slave ramBus
);

    logic [31:0] mem [localBusPkg::RAM_WORDS];
    logic [31:0] rdataQ;
    logic [localBusPkg::WAIT_W-1:0] waitCnt;
    logic waiting;
    logic [localBusPkg::BEAT_W-1:0] beatsLeft;
    logic [localBusPkg::RAM_ADDR_W-1:0] curAddr;
    logic [localBusPkg::RAM_ADDR_W-1:0] nextAddr;
    logic [localBusPkg::RAM_ADDR_W-1:0] rdAddr;
    logic burstHeld;
    logic grantNow;
    logic taQ;
    logic fetch;                                        // First beat loads from memory.
    logic step;                                         // Move on to the next beat.

    // Only a burst with DMA waiting is refused. Single beats need no inhibit.
    assign grantNow = !(ramBus.burst && dmaReq);
    assign ramBus.burstCycle = ramBus.request ? grantNow : burstHeld;

    // Low bits wrap inside the 16-byte line.
    assign nextAddr = {curAddr[localBusPkg::RAM_ADDR_W-1:localBusPkg::BEAT_W],
                       curAddr[localBusPkg::BEAT_W-1:0] + 1'b1};

    assign fetch = waiting && (waitCnt == '0);
    assign step = taQ && (beatsLeft != '0);
    assign rdAddr = step ? nextAddr : curAddr;

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            waiting <= 1'b0;
            waitCnt <= '0;
            beatsLeft <= '0;
            curAddr <= '0;
            burstHeld <= 1'b0;
            taQ <= 1'b0;
        end else begin
            if (ramBus.request) begin
                waiting <= 1'b1;
                waitCnt <= localBusPkg::WAIT_LOAD;
                curAddr <= ramBus.wordAddr;
                burstHeld <= grantNow;                  // Decided once per cycle.
                beatsLeft <= (ramBus.burst && grantNow) ? localBusPkg::LAST_BEAT : '0;
            end else if (fetch) begin
                waiting <= 1'b0;
            end else if (waiting) begin
                waitCnt <= waitCnt - 1'b1;
            end
            if (fetch) begin
                taQ <= 1'b1;                            // First beat at RAM_WAIT.
            end else if (step) begin
                taQ <= 1'b1;                            // Back-to-back beats.
                beatsLeft <= beatsLeft - 1'b1;
                curAddr <= nextAddr;
            end else begin
                taQ <= 1'b0;
            end
        end
    end

    // Block memory port. Write at the end of a beat, read ahead of the next.
    always_ff @(posedge CLK40) begin
        if (taQ && !ramBus.rnw) begin
            mem[curAddr] <= ramBus.wdata;
        end
        if (fetch || step) begin
            rdataQ <= mem[rdAddr];
        end
    end

    assign ramBus.ta = taQ;
    assign ramBus.rdata = (taQ && ramBus.rnw) ? rdataQ : '0;

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
// Four read/write control registers that acknowledge a fixed number of cycles after transfer start.
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input logic CLK40,
    input logic nRESET,
    regBusIf.slave regBus
);

    logic [31:0] regs [localBusPkg::REG_COUNT];
    logic [localBusPkg::REG_WAIT-1:0] taPipe;           // Request delayed toward REG_WAIT.

    // Request is seen at edge 1, so the pipe reaches its end at edge REG_WAIT.
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            taPipe <= '0;
        end else begin
            taPipe <= {taPipe[localBusPkg::REG_WAIT-2:0], regBus.request};
        end
    end

    assign regBus.ta = taPipe[localBusPkg::REG_WAIT-1];

    // Write lands on the edge that ends the nTa-low cycle.
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            for (int i = 0; i < localBusPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regBus.ta && !regBus.rnw) begin
            regs[regBus.index] <= regBus.wdata;
        end
    end

    // Read data shows only with the acknowledge.
    assign regBus.rdata = (regBus.ta && regBus.rnw) ? regs[regBus.index] : '0;

endmodule

`default_nettype wire

// File: hdl/transferAck.sv
// Drives the shared nTa and nTbi strobes from the datapath acknowledges while this slave owns the cycle.
`timescale 1ns/10ps
`default_nettype none

module transferAck (
    input logic CLK40,
    input logic nRESET,
    input logic regTa,
    input logic ramTa,
    input logic burstCycle,
    input localBusPkg::busSpace_e space,
    output tri nTa,
    output tri nTbi
);

    logic ta;
    logic taSpace;                                      // nTa output enable.
    logic tbiSpace;                                     // nTbi output enable.
    logic trailCycle;                                   // Cycle after an acknowledge.

    assign ta = regTa || ramTa;

    // Hold nTa high after the last beat so the next cycle cannot end early.
    assign taSpace = (space != localBusPkg::SPACE_NONE) || trailCycle;
    assign nTa = taSpace ? !ta : 1'bz;

    // Burst inhibit only when DMA turned a RAM burst into a single beat.
    assign tbiSpace = (space == localBusPkg::SPACE_RAM) && !burstCycle;
    assign nTbi = tbiSpace ? !ta : 1'bz;

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            trailCycle <= 1'b0;
        end else begin
            trailCycle <= ta && taSpace;
        end
    end

    // Only one datapath answers a cycle.
    oneTaSource: assert property (
        @(posedge CLK40) disable iff (!nRESET)
        !(regTa && ramTa)
    );

endmodule

`default_nettype wire

// File: testbench/cpuLocalBusTb.sv
// Testbench for the local-bus slave; runs register, RAM, burst and unclaimed cycles under assertions.
`timescale 1ns/10ps
`default_nettype none

module cpuLocalBusTb;

    logic CLK40;
    logic nRESET;
    logic nTs;
    logic [31:0] addr;
    logic rnw;
    logic lineBurst;
    logic [31:0] writeData;
    logic dmaReq;
    logic [31:0] readData;
    tri nTa;
    tri nTbi;

    logic [31:0] refRegs [localBusPkg::REG_COUNT];      // Reference register contents.
    logic [31:0] refRam [localBusPkg::RAM_WORDS];       // Reference RAM contents.
    logic [31:0] beatData [localBusPkg::BEATS_PER_LINE]; // Write data per beat.

    // Shape of the running cycle, updated 1 ns after each edge.
    logic cycClaimed;
    logic cycRefused;                                   // Burst refused for DMA.
    int phase;                                          // Edges since nTs was sampled low.
    int lowStart;                                       // Phase of the first nTa-low cycle.
    int beats;
    logic [31:0] expRead;                               // Expected readData this cycle.
    logic expNTa;
    logic expNTbi;

    cpuLocalBus cpuLocalBus_i (
        .CLK40(CLK40),
        .nRESET(nRESET),
        .nTs(nTs),
        .addr(addr),
        .rnw(rnw),
        .lineBurst(lineBurst),
        .writeData(writeData),
        .dmaReq(dmaReq),
        .readData(readData),
        .nTa(nTa),
        .nTbi(nTbi)
    );

    initial begin
        CLK40 = 1'b0;
        forever #4 CLK40 = ~CLK40;                      // 8 ns period.
    end

    // Strobe level per phase: high before the beats, low on beats, one high, then released.
    function automatic logic expectedNTa(input logic claimed, input int ph, input int start,
                                         input int n);
        if (!claimed || ph < 0 || ph > start + n) begin
            return 1'bz;
        end else if (ph >= start && ph < start + n) begin
            return 1'b0;
        end else begin
            return 1'b1;
        end
    endfunction

    assign expNTa = expectedNTa(cycClaimed, phase, lowStart, beats);
    // Inhibit follows nTa only on a refused burst, from edge 0 through recovery.
    assign expNTbi = (cycRefused && phase >= 0 && phase <= lowStart + beats) ? expNTa : 1'bz;

    // Longword hit by beat k, wrapping inside the 16-byte line.
    function automatic logic [localBusPkg::RAM_ADDR_W-1:0] beatWord(input logic [31:0] a,
                                                                   input int k);
        logic [1:0] low;
        low = a[3:2] + 2'(k);
        return {a[11:4], low};
    endfunction

    function automatic logic [31:0] ramAddr(input logic [localBusPkg::RAM_ADDR_W-1:0] w);
        return localBusPkg::RAM_BASE | {20'h0, w, 2'b00};
    endfunction

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic fillBeats();
        for (int k = 0; k < localBusPkg::BEATS_PER_LINE; k++) begin
            beatData[k] = $urandom;
        end
    endtask

    // One CPU bus cycle, entered and left 1 ns after a rising edge.
    task automatic busCycle(input logic [31:0] a, input logic rd, input logic burst,
                            input logic dma);
        logic isReg;
        logic isRam;
        int seen;
        logic [localBusPkg::RAM_ADDR_W-1:0] word;
        isReg = a[31:4] == localBusPkg::REG_BASE[31:4];
        isRam = a[31:12] == localBusPkg::RAM_BASE[31:12];
        cycClaimed = isReg || isRam;
        cycRefused = isRam && burst && dma;
        beats = (isRam && burst && !dma) ? localBusPkg::BEATS_PER_LINE : 1;
        lowStart = isReg ? localBusPkg::REG_WAIT : localBusPkg::RAM_WAIT;
        phase = -1;
        seen = 0;
        addr = a;
        rnw = rd;
        lineBurst = burst;
        dmaReq = dma;                                   // Seen by the RAM with the request.
        writeData = beatData[0];
        nTs = 1'b0;
        @(posedge CLK40);
        #1;
        nTs = 1'b1;                                     // Single-cycle start strobe.
        phase = 0;
        while (cycClaimed && seen < beats) begin
            @(posedge CLK40);
            #1;
            phase++;
            expRead = '0;
            if (phase > 50) begin
                stopOnError("Timeout: nTa did not acknowledge the cycle within 50 cycles.");
            end else if (nTa === 1'b0) begin
                word = beatWord(a, seen);
                writeData = beatData[seen];             // Taken on the edge ending the beat.
                if (isReg && rd) begin
                    expRead = refRegs[a[3:2]];
                end else if (isReg) begin
                    refRegs[a[3:2]] = beatData[seen];
                end else if (rd) begin
                    expRead = refRam[word];
                end else begin
                    refRam[word] = beatData[seen];
                end
                seen++;
            end
        end
        // Recovery and release, or 8 quiet cycles when nobody claims the address.
        repeat (cycClaimed ? 2 : 8) begin
            @(posedge CLK40);
            #1;
            phase++;
            expRead = '0;
        end
    endtask

    nTaCheck: assert property (@(posedge CLK40) disable iff (!nRESET) nTa === expNTa)
        else stopOnError($sformatf("Fail nTa expected %h got %h", $sampled(expNTa),
                                   $sampled(nTa)));

    nTbiCheck: assert property (@(posedge CLK40) disable iff (!nRESET) nTbi === expNTbi)
        else stopOnError($sformatf("Fail nTbi expected %h got %h", $sampled(expNTbi),
                                   $sampled(nTbi)));

    readDataCheck: assert property (@(posedge CLK40) disable iff (!nRESET) readData === expRead)
        else stopOnError($sformatf("Fail readData expected %h got %h", $sampled(expRead),
                                   $sampled(readData)));

    initial begin
        logic [localBusPkg::RAM_ADDR_W-1:0] words [8];
        logic [localBusPkg::RAM_ADDR_W-1:0] start;
        void'($urandom(56051));
        nRESET = 1'b0;
        nTs = 1'b1;
        addr = '0;
        rnw = 1'b1;
        lineBurst = 1'b0;
        writeData = '0;
        dmaReq = 1'b0;
        cycClaimed = 1'b0;
        cycRefused = 1'b0;
        phase = -1;
        lowStart = 0;
        beats = 0;
        expRead = '0;
        for (int i = 0; i < localBusPkg::REG_COUNT; i++) begin
            refRegs[i] = '0;                            // Registers reset to zero.
        end
        repeat (16) @(posedge CLK40);
        #1;
        nRESET = 1'b1;
        repeat (4) @(posedge CLK40);                    // Idle bus right after reset.
        #1;
        for (int i = 0; i < localBusPkg::REG_COUNT; i++) begin
            fillBeats();
            busCycle(localBusPkg::REG_BASE + 32'(4 * i), 1'b0, 1'b0, 1'b0);
            busCycle(localBusPkg::REG_BASE + 32'(4 * i), 1'b1, 1'b0, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            words[i] = localBusPkg::RAM_ADDR_W'($urandom);
            fillBeats();
            busCycle(ramAddr(words[i]), 1'b0, 1'b0, 1'b0);
        end
        for (int i = 7; i >= 0; i--) begin
            busCycle(ramAddr(words[i]), 1'b1, 1'b0, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            start = localBusPkg::RAM_ADDR_W'($urandom);
            fillBeats();
            busCycle(ramAddr(start), 1'b0, 1'b1, 1'b0);                      // Line write.
            busCycle(ramAddr({start[9:2], 2'(start[1:0] + 2'd1)}), 1'b1, 1'b1, 1'b0);
        end
        busCycle(ramAddr(start), 1'b1, 1'b1, 1'b1);     // Refused burst read.
        fillBeats();
        busCycle(ramAddr(start ^ 10'h1), 1'b0, 1'b1, 1'b1);   // Refused burst write.
        busCycle(ramAddr(start), 1'b1, 1'b1, 1'b0);     // Only one word of the line moved.
        busCycle(32'h1000_0000, 1'b1, 1'b0, 1'b0);      // Outside both spaces.
        busCycle(localBusPkg::REG_BASE + 32'h8, 1'b1, 1'b0, 1'b0);
        repeat (4) @(posedge CLK40);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
